// File: source/adc_intf_pkg.sv
// shared widths and gain codes; fifo_depth must stay a power of two for the pointer wrap
package adc_intf_pkg;

    // one lane of I or Q samples
    localparam int iq_data_width = 16;

    // lane order in the word, low to high: I0, Q0, I1, Q1
    localparam int num_lanes = 4;

    // full ADC word, all lanes side by side
    localparam int sample_width = iq_data_width * num_lanes;

    localparam int fifo_depth       = 16;                  // words held between ADC and baseband
    localparam int fifo_addr_width  = 4;                   // ring pointer width
    localparam int fifo_count_width = fifo_addr_width + 1; // one extra bit so full is countable

    // baseband gain select
    localparam int gain_code_width = 3;

    // shift amounts per gain step, in bits
    localparam int gain_shift_width = 3;      // largest shift is 6
    localparam int gain_default_shift = 4;    // x16, also used for unlisted codes

    // codes the baseband may program; anything else falls back to x16
    typedef enum logic [gain_code_width-1:0] {
        gain_x8  = 3'd3,   // shift by 3
        gain_x16 = 3'd4,   // shift by 4, default
        gain_x32 = 3'd5,   // shift by 5
        gain_x64 = 3'd6    // shift by 6
    } gain_code_e;

    // codes 0, 1, 2 and 7 have no name
    // bb_gain_align maps them onto gain_default_shift

    // no overflow or saturation on the shift
    // high bits of each lane simply fall off

endpackage

// File: source/adc_decimator.sv
// keeps every second valid word; phase moves only on adc_valid, so no word is repeated
module adc_decimator
    import adc_intf_pkg::*;
(
    input  logic                    adc_clk,
    input  logic                    adc_rst,
    input  logic [sample_width-1:0] adc_data,   // four lanes, I0 in the low bits
    input  logic                    adc_valid,  // one word per high cycle
    output logic [sample_width-1:0] wr_data,    // kept word, registered
    output logic                    wr_en       // single-cycle write strobe
);

    logic phase;   // 0 on the first word of a pair, 1 on the second
    logic keep;    // this edge sees the second word of a pair

    assign keep = adc_valid && phase;

    // phase bit
    // toggles only on a seen word so gaps in adc_valid don't move it
    always_ff @(posedge adc_clk) begin
        if (adc_rst) begin
            phase <= 1'b0;   // first valid word after reset is dropped
        end else if (adc_valid) begin
            phase <= ~phase;
        end
    end

    // write strobe
    // high for one cycle after each kept word and never two in a row
    always_ff @(posedge adc_clk) begin
        if (adc_rst) begin
            wr_en <= 1'b0;
        end else begin
            wr_en <= keep;
        end
    end

    // payload register
    // loads only on kept words
    // holds its value between strobes while the FIFO ignores it
    always_ff @(posedge adc_clk) begin
        if (keep) begin
            wr_data <= adc_data;
        end
    end

    // rate at the FIFO input is half the valid-word rate
    // latency from the kept word to wr_en is one cycle

endmodule

// File: source/sample_fifo.sv
// single-clock FWFT FIFO; writes while full are lost and set overflow, cleared only by adc_rst
module sample_fifo
    import adc_intf_pkg::*;
(
    input  logic                    adc_clk,
    input  logic                    adc_rst,
    input  logic [sample_width-1:0] wr_data,   // word from the decimator
    input  logic                    wr_en,     // write strobe
    input  logic                    rd_en,     // pop request from baseband
    output logic [sample_width-1:0] rd_data,   // head word, valid while emptyn
    output logic                    emptyn,    // at least one word held
    output logic                    overflow   // a write was dropped since reset
);

    // storage
    logic [sample_width-1:0]     mem [fifo_depth];   // ring of words

    // ring state
    logic [fifo_addr_width-1:0]  wr_ptr;    // next slot to fill
    logic [fifo_addr_width-1:0]  rd_ptr;    // current head slot
    logic [fifo_count_width-1:0] count;     // 0 .. fifo_depth

    // derived flags
    logic full;
    logic do_wr;   // accepted write
    logic do_rd;   // accepted pop

    // flags from the count held before the edge
    assign full   = (count == fifo_count_width'(fifo_depth));
    assign emptyn = (count != '0);

    // full is judged before the edge
    // a pop at the same edge does not rescue the write
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && emptyn;   // pop on empty is ignored

    // first word fall through
    // head slot drives the output directly with no read latency
    assign rd_data = mem[rd_ptr];

    // memory write port
    always_ff @(posedge adc_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // write pointer
    always_ff @(posedge adc_clk) begin
        if (adc_rst) begin
            wr_ptr <= '0;
        end else if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;   // wraps at fifo_depth
        end
    end

    // read pointer
    always_ff @(posedge adc_clk) begin
        if (adc_rst) begin
            rd_ptr <= '0;
        end else if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;   // next word shows after this edge
        end
    end

    // occupancy
    always_ff @(posedge adc_clk) begin
        if (adc_rst) begin
            count <= '0;
        end else begin
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;   // write only
                2'b01:   count <= count - 1'b1;   // pop only
                default: count <= count;          // both or neither
            endcase
        end
    end

    // sticky overflow
    // rises on the first lost write
    // nothing but reset clears it
    always_ff @(posedge adc_clk) begin
        if (adc_rst) begin
            overflow <= 1'b0;
        end else if (wr_en && full) begin
            overflow <= 1'b1;
        end
    end

    // a lost word leaves the ring untouched
    // the words already queued keep their order

endmodule

// File: source/bb_gain_align.sv
// purely combinational per-lane left shift; no saturation, high bits of each lane are lost
module bb_gain_align
    import adc_intf_pkg::*;
(
    input  logic [gain_code_width-1:0] bb_gain,     // raw code from baseband
    input  logic [sample_width-1:0]    rd_data,     // FIFO head word
    output logic [sample_width-1:0]    data_to_bb   // scaled word
);

    gain_code_e                  gain_code;    // typed view of bb_gain
    logic [gain_shift_width-1:0] lane_shift;   // 3 .. 6

    assign gain_code = gain_code_e'(bb_gain);

    // code to shift amount
    // unlisted codes land on the default step
    always_comb begin
        case (gain_code)
            gain_x8:  lane_shift = gain_shift_width'(3);
            gain_x16: lane_shift = gain_shift_width'(4);
            gain_x32: lane_shift = gain_shift_width'(5);
            gain_x64: lane_shift = gain_shift_width'(6);
            default:  lane_shift = gain_shift_width'(gain_default_shift);   // 0, 1, 2, 7
        endcase
    end

    // per-lane shift
    // each lane is shifted inside its own 16-bit slice
    // zeros fill from the bottom, nothing leaks into the lane above
    always_comb begin
        for (int lane = 0; lane < num_lanes; lane++) begin
            data_to_bb[lane*iq_data_width +: iq_data_width] =
                rd_data[lane*iq_data_width +: iq_data_width] << lane_shift;   // 16-bit context
        end
    end

    // a gain change shows on data_to_bb in the same cycle
    // the head word is not consumed by the shift

    // lane sign is not preserved
    // a large sample at x64 wraps within its lane

    // when the FIFO is empty data_to_bb follows stale head data
    // the baseband must qualify it with emptyn_to_bb

endmodule

// File: source/adc_intf.sv
// single-clock front end; baseband runs on adc_clk, back-pressure only through bb_ask_data
module adc_intf
    import adc_intf_pkg::*;
(
    input  logic                       adc_clk,
    input  logic                       adc_rst,        // synchronous, active high
    input  logic [sample_width-1:0]    adc_data,       // I0, Q0, I1, Q1
    input  logic                       adc_valid,
    input  logic [gain_code_width-1:0] bb_gain,        // see gain_code_e
    input  logic                       bb_ask_data,    // pop strobe
    output logic [sample_width-1:0]    data_to_bb,     // scaled head word
    output logic                       emptyn_to_bb,   // head word is valid
    output logic                       overflow        // sticky, words were lost
);

    // decimator to FIFO
    logic [sample_width-1:0] wr_data;   // kept word
    logic                    wr_en;     // one pulse per kept word

    // FIFO to gain stage
    logic [sample_width-1:0] rd_data;   // unscaled head

    // 2:1 rate reduction
    adc_decimator u_decimator (
        .adc_clk   (adc_clk),
        .adc_rst   (adc_rst),
        .adc_data  (adc_data),
        .adc_valid (adc_valid),
        .wr_data   (wr_data),
        .wr_en     (wr_en)
    );

    // 16-word buffer
    // pop comes straight from the baseband strobe
    sample_fifo u_fifo (
        .adc_clk  (adc_clk),
        .adc_rst  (adc_rst),
        .wr_data  (wr_data),
        .wr_en    (wr_en),
        .rd_en    (bb_ask_data),
        .rd_data  (rd_data),
        .emptyn   (emptyn_to_bb),
        .overflow (overflow)
    );

    // scaling on the way out, no register
    bb_gain_align u_gain (
        .bb_gain    (bb_gain),
        .rd_data    (rd_data),
        .data_to_bb (data_to_bb)
    );

    // earliest arrival at data_to_bb is one cycle after the kept word's edge
    // later words wait behind the queue

endmodule

// File: tests/adc_intf_tb.sv
// random traffic checked against a queue model; seed fixed, watchdog bounds run time, adc_clk only
module adc_intf_tb
    import adc_intf_pkg::*;
;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 3;
    localparam int phase_cycles = 400;
    localparam int num_phases   = 4;
    localparam int tail_cycles  = 4;     // settle after the closing reset
    localparam int margin       = 100;
    // two resets, four phases, tail, margin
    localparam int run_cycles   =
        2 * reset_cycles + num_phases * phase_cycles + tail_cycles + margin;

    // DUT ports
    logic                    adc_clk;
    logic                    adc_rst;
    logic [sample_width-1:0] adc_data;
    logic                    adc_valid;
    logic [2:0]              bb_gain;
    logic                    bb_ask_data;
    logic [sample_width-1:0] data_to_bb;
    logic                    emptyn_to_bb;
    logic                    overflow;

    // reference model state
    logic [sample_width-1:0] model_q [$];     // words held in the FIFO
    logic                    model_phase;     // decimator pair position
    logic                    pend_valid;      // decimator register holds a write
    logic [sample_width-1:0] pend_data;
    logic                    model_ovf;       // sticky drop flag

    // bookkeeping
    int    delivered;     // pops of real words
    int    dropped;       // writes lost on full
    int    empty_reads;   // bb_ask_data with nothing queued
    bit    check_en;
    string test_name;

    adc_intf u_dut (
        .adc_clk      (adc_clk),
        .adc_rst      (adc_rst),
        .adc_data     (adc_data),
        .adc_valid    (adc_valid),
        .bb_gain      (bb_gain),
        .bb_ask_data  (bb_ask_data),
        .data_to_bb   (data_to_bb),
        .emptyn_to_bb (emptyn_to_bb),
        .overflow     (overflow)
    );

    always #(clk_period / 2) adc_clk = ~adc_clk;

    // codes 3..6 map to their own shift and everything else is x16
    function automatic int gain_shift(input logic [2:0] code);
        int shift;
        case (code)
            3'd3:    shift = 3;
            3'd4:    shift = 4;
            3'd5:    shift = 5;
            3'd6:    shift = 6;
            default: shift = 4;   // 0, 1, 2, 7
        endcase
        return shift;
    endfunction

    // per-lane shift drops bits past the lane top
    function automatic logic [sample_width-1:0] scale_word(
        input logic [sample_width-1:0] word,
        input logic [2:0]              code
    );
        logic [sample_width-1:0]  result;
        logic [iq_data_width-1:0] lane_val;
        int                       shift;
        shift = gain_shift(code);
        for (int lane = 0; lane < num_lanes; lane++) begin
            lane_val = word[lane*iq_data_width +: iq_data_width];
            lane_val = lane_val << shift;   // stays 16 bits wide
            result[lane*iq_data_width +: iq_data_width] = lane_val;
        end
        return result;
    endfunction

    // compare and stop on first mismatch
    task automatic check_value(
        input string                   what,
        input logic [sample_width-1:0] expected,
        input logic [sample_width-1:0] actual
    );
        assert (actual === expected) else begin
            $display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // failure without a value to show
    task automatic check_true(input bit cond, input string reason);
        assert (cond) else begin
            $display("%s: %s", test_name, reason);
            $display("SIMULATION FAILED");
            $fatal(1, "check failed");
        end
    endtask

    // one stimulus phase with percentages out of 100
    task automatic run_phase(
        input string name,
        input int    valid_pct,
        input int    ask_pct,
        input bit    random_gain,
        input [2:0]  fixed_gain
    );
        test_name = name;
        repeat (phase_cycles) begin
            @(posedge adc_clk);
            adc_valid   <= ($urandom % 100) < valid_pct;
            adc_data    <= {$urandom, $urandom};
            bb_ask_data <= ($urandom % 100) < ask_pct;
            bb_gain     <= random_gain ? 3'($urandom % 8) : fixed_gain;   // includes 0,1,2,7
        end
    endtask

    // model update sees the inputs as the DUT does at this edge
    always @(posedge adc_clk) begin : model_update
        int size_before;
        size_before = model_q.size();
        if (adc_rst) begin
            model_q.delete();
            model_phase = 1'b0;
            pend_valid  = 1'b0;
            model_ovf   = 1'b0;
        end else begin
            // write from decimator register with full judged before any pop
            if (pend_valid) begin
                if (size_before >= fifo_depth) begin
                    model_ovf = 1'b1;
                    dropped++;
                end else begin
                    model_q.push_back(pend_data);
                end
            end
            if (bb_ask_data) begin
                if (size_before > 0) begin
                    void'(model_q.pop_front());
                    delivered++;
                end else begin
                    empty_reads++;   // ignored by the FIFO
                end
            end
            pend_valid = adc_valid && model_phase;   // second word of a pair
            if (pend_valid) pend_data = adc_data;
            if (adc_valid) model_phase = ~model_phase;
        end
    end

    // outputs compared mid-cycle away from the edge
    always @(negedge adc_clk) begin
        if (check_en) begin
            check_value("emptyn_to_bb", (model_q.size() != 0), emptyn_to_bb);
            check_value("overflow", model_ovf, overflow);
            if (model_q.size() != 0) begin
                check_value("data_to_bb", scale_word(model_q[0], bb_gain), data_to_bb);
            end
        end
    end

    // watchdog
    initial begin
        #(run_cycles * clk_period);
        $display("watchdog expired after %0d cycles, the run hung", run_cycles);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        void'($urandom(32'hb20b));   // seeds this process once
        adc_clk     = 1'b0;
        adc_rst     = 1'b1;
        adc_data    = '0;
        adc_valid   = 1'b0;
        bb_gain     = 3'd4;
        bb_ask_data = 1'b0;
        delivered   = 0;
        dropped     = 0;
        empty_reads = 0;
        check_en    = 1'b0;
        test_name   = "reset";

        repeat (reset_cycles) @(posedge adc_clk);
        adc_rst  <= 1'b0;
        check_en = 1'b1;
        @(negedge adc_clk);
        check_value("emptyn_to_bb after reset", '0, emptyn_to_bb);
        check_value("overflow after reset", '0, overflow);

        run_phase("light_traffic", 30, 50, 1'b0, 3'd3);
        run_phase("overflow_fill", 95, 5, 1'b0, 3'd5);
        check_true(dropped > 0, "FIFO never overflowed under heavy ADC traffic");
        run_phase("drain", 50, 100, 1'b0, 3'd6);
        run_phase("mixed_gain", 60, 50, 1'b1, 3'd4);

        // overflow must have held through drain and mixed phases
        test_name = "final_reset";
        @(negedge adc_clk);
        check_value("overflow before reset", 1'b1, overflow);
        check_true(delivered > 0, "no word ever reached the baseband");
        check_true(empty_reads > 0, "no read request was made while empty");
        @(posedge adc_clk);
        adc_rst     <= 1'b1;
        adc_valid   <= 1'b0;
        bb_ask_data <= 1'b0;
        repeat (reset_cycles) @(posedge adc_clk);
        adc_rst <= 1'b0;
        repeat (tail_cycles) @(posedge adc_clk);
        @(negedge adc_clk);
        check_value("overflow after reset", '0, overflow);   // sticky only until reset

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: project.f
source/adc_intf_pkg.sv
source/adc_decimator.sv
source/sample_fifo.sv
source/bb_gain_align.sv
source/adc_intf.sv
tests/adc_intf_tb.sv

// File: Bender.yml
package:
  name: adc_intf

sources:
  # package first, then leaf modules, then the top level
  - files:
      - source/adc_intf_pkg.sv
      - source/adc_decimator.sv
      - source/sample_fifo.sv
      - source/bb_gain_align.sv
      - source/adc_intf.sv

  # testbench, top module adc_intf_tb
  - target: test
    files:
      - tests/adc_intf_tb.sv
